// ==== common/fp_nr_pkg.sv ====
// Shared types for the single-precision normalize-and-round back end
// Mantissa layout is {carry, safe, hidden, frac, grs} with guard at the top of grs
// Rounding mode codes follow RISC-V, codes 5 to 7 are treated as RNE
// Request exponents are biased and unsigned, range checks happen after normalization

package fp_nr_pkg;

    localparam int EXPO_WIDTH = 8;
    localparam int FRAC_WIDTH = 23;
    localparam int GRS_WIDTH = 3;
    localparam int SHIFT_WIDTH = 3 + FRAC_WIDTH + GRS_WIDTH;
    localparam int EXPO_MAX = (1 << EXPO_WIDTH) - 1;
    localparam int NUM_WB_UNITS_DEFAULT = 4;

    typedef logic [2:0] rm_t;
    localparam rm_t RM_RNE = 3'd0;
    localparam rm_t RM_RTZ = 3'd1;
    localparam rm_t RM_RDN = 3'd2;
    localparam rm_t RM_RUP = 3'd3;
    localparam rm_t RM_RMM = 3'd4;

    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef logic [3:0] id_t;
    typedef logic signed [EXPO_WIDTH+1:0] expo_d_t;
    typedef logic [4:0] shift_amt_t;

    typedef struct packed {
        logic sign;
        logic [EXPO_WIDTH-1:0] expo;
        logic [FRAC_WIDTH-1:0] frac;
    } fp_t;

    // One unrounded result offered by an arithmetic unit
    typedef struct packed {
        id_t id;
        logic sign;
        logic [EXPO_WIDTH-1:0] expo;
        logic carry;
        logic safe;
        logic hidden;
        logic [FRAC_WIDTH-1:0] frac;
        logic [GRS_WIDTH-1:0] grs;
        fflags_t fflags;
        rm_t rm;
        logic right_shift;
        shift_amt_t right_shift_amt;
        shift_amt_t clz;
    } wb_req_t;

    typedef struct packed {
        id_t id;
        fp_t rd;
        fflags_t fflags;
    } wb_result_t;

    typedef struct packed {
        logic valid;
        wb_req_t req;
    } norm_packet_t;

    typedef struct packed {
        logic valid;
        id_t id;
        logic sign;
        rm_t rm;
        fflags_t fflags;
        expo_d_t expo_norm;
        logic expo_overflow;
        logic right_shift;
        shift_amt_t shift_amt;
        logic [SHIFT_WIDTH-1:0] shifter_in;
    } shift_packet_t;

    typedef struct packed {
        logic valid;
        id_t id;
        logic sign;
        rm_t rm;
        fflags_t fflags;
        logic [EXPO_WIDTH-1:0] expo;
        logic [FRAC_WIDTH-1:0] frac;
        logic expo_overflow;
        logic hidden;
        logic round_lsb;
        logic [2:0] round_grs;
    } round_packet_t;

    typedef struct packed {
        logic roundup;
        fp_t overflow_result;
    } roundup_t;

    //////////////////////////////////////////////////////////////////////
    // Shared functions

    function automatic logic [SHIFT_WIDTH-1:0] fp_reverse(input logic [SHIFT_WIDTH-1:0] in);
        logic [SHIFT_WIDTH-1:0] out;
        for (int i = 0; i < SHIFT_WIDTH; i++) begin
            out[i] = in[SHIFT_WIDTH-1-i];
        end
        return out;
    endfunction

    // grs is {guard, round, sticky} below the kept lsb
    function automatic roundup_t fp_roundup(input logic sign, input rm_t rm,
                                            input logic [2:0] grs, input logic lsb);
        roundup_t rv;
        logic to_max;
        rv.roundup = 1'b0;
        to_max = 1'b0;
        case (rm)
            RM_RTZ: to_max = 1'b1;
            RM_RDN: begin
                rv.roundup = sign & (|grs);
                to_max = ~sign;
            end
            RM_RUP: begin
                rv.roundup = ~sign & (|grs);
                to_max = sign;
            end
            RM_RMM: rv.roundup = grs[2];
            default: rv.roundup = grs[2] & (grs[1] | grs[0] | lsb);
        endcase
        // Infinity, or the largest finite magnitude when rounding toward zero
        rv.overflow_result.sign = sign;
        rv.overflow_result.expo = to_max ? EXPO_WIDTH'(EXPO_MAX - 1) : EXPO_WIDTH'(EXPO_MAX);
        rv.overflow_result.frac = to_max ? '1 : '0;
        return rv;
    endfunction

endpackage

// ==== norm_round/fp_normalize_stage.sv ====
// Works out shift direction, amount and the normalized exponent
// Left shifts stop at the subnormal boundary, exponent then reads 0
// The request exponent is assumed nonzero whenever a left shift is asked for
// Left shifts are bit-reversed so a single right shifter covers both ways
`timescale 1ns/100ps

module fp_normalize_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  fp_nr_pkg::norm_packet_t     norm_pkt,
    input  logic                        advance_next,
    output logic                        advance,
    output fp_nr_pkg::shift_packet_t    shift_pkt
);
    import fp_nr_pkg::*;

    expo_d_t expo_ext;
    expo_d_t clz_ext;
    expo_d_t rshift_ext;
    logic left_clamp;
    shift_amt_t shift_amt;
    expo_d_t expo_norm;
    logic expo_overflow;
    logic [SHIFT_WIDTH-1:0] in_right;

    assign expo_ext = expo_d_t'(norm_pkt.req.expo);
    assign clz_ext = expo_d_t'(norm_pkt.req.clz);
    assign rshift_ext = expo_d_t'(norm_pkt.req.right_shift_amt);

    // Full clz would push the exponent below 1
    assign left_clamp = expo_ext <= clz_ext;

    always_comb begin
        if (norm_pkt.req.right_shift) begin
            shift_amt = norm_pkt.req.right_shift_amt;
            expo_norm = expo_ext + rshift_ext;
        end else if (!left_clamp) begin
            shift_amt = norm_pkt.req.clz;
            expo_norm = expo_ext - clz_ext;
        end else begin
            // Only shift down to the scale of exponent 1
            shift_amt = (expo_ext == '0) ? '0 : shift_amt_t'(expo_ext - expo_d_t'(1));
            expo_norm = '0;
        end
    end

    assign expo_overflow = expo_norm >= expo_d_t'(EXPO_MAX);

    assign in_right = {norm_pkt.req.carry, norm_pkt.req.safe, norm_pkt.req.hidden,
                       norm_pkt.req.frac, norm_pkt.req.grs};

    //////////////////////////////////////////////////////////////////////
    // Second stage register

    assign advance = advance_next | ~shift_pkt.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            shift_pkt.valid <= 1'b0;
        end else if (advance) begin
            shift_pkt.valid <= norm_pkt.valid;
        end

        if (advance) begin
            shift_pkt.id <= norm_pkt.req.id;
            shift_pkt.sign <= norm_pkt.req.sign;
            shift_pkt.rm <= norm_pkt.req.rm;
            shift_pkt.fflags <= norm_pkt.req.fflags;
            shift_pkt.expo_norm <= expo_norm;
            shift_pkt.expo_overflow <= expo_overflow;
            shift_pkt.right_shift <= norm_pkt.req.right_shift;
            shift_pkt.shift_amt <= shift_amt;
            shift_pkt.shifter_in <= norm_pkt.req.right_shift ? in_right : fp_reverse(in_right);
        end
    end

endmodule

// ==== norm_round/fp_shift_extract.sv ====
// Shifts the mantissa and pulls out the bits that rounding needs
// Bits shifted out on a right shift fold into the sticky position
// Carry and safe positions are expected to be clear after normalization
`timescale 1ns/100ps

module fp_shift_extract (
    input  logic                        clk,
    input  logic                        rst,
    input  fp_nr_pkg::shift_packet_t    shift_pkt,
    input  logic                        advance_next,
    output logic                        advance,
    output fp_nr_pkg::round_packet_t    round_pkt
);
    import fp_nr_pkg::*;

    logic [SHIFT_WIDTH-1:0] shift_mid;
    logic [SHIFT_WIDTH-1:0] shift_final;
    logic [SHIFT_WIDTH-1:0] lost_mask;
    logic shifted_out;
    logic [GRS_WIDTH-1:0] grs_norm;
    logic [FRAC_WIDTH-1:0] frac_norm;
    logic hidden_norm;
    logic [2:0] round_grs;
    fflags_t fflags_next;

    //////////////////////////////////////////////////////////////////////
    // Shifter

    assign shift_mid = shift_pkt.shifter_in >> shift_pkt.shift_amt;
    // Undo the input reversal for left shifts
    assign shift_final = shift_pkt.right_shift ? shift_mid : fp_reverse(shift_mid);

    // Low bits that drop off the bottom
    assign lost_mask = ~({SHIFT_WIDTH{1'b1}} << shift_pkt.shift_amt);
    assign shifted_out = shift_pkt.right_shift & (|(shift_pkt.shifter_in & lost_mask));

    //////////////////////////////////////////////////////////////////////
    // Round bit extraction

    assign grs_norm = shift_final[GRS_WIDTH-1:0];
    assign frac_norm = shift_final[GRS_WIDTH+FRAC_WIDTH-1:GRS_WIDTH];
    assign hidden_norm = shift_final[GRS_WIDTH+FRAC_WIDTH];

    assign round_grs[2:1] = grs_norm[GRS_WIDTH-1 -: 2];
    assign round_grs[0] = (|grs_norm[GRS_WIDTH-3:0]) | shifted_out;

    always_comb begin
        fflags_next = shift_pkt.fflags;
        fflags_next.nx = shift_pkt.fflags.nx | (|round_grs);
    end

    //////////////////////////////////////////////////////////////////////
    // Third stage register

    assign advance = advance_next | ~round_pkt.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            round_pkt.valid <= 1'b0;
        end else if (advance) begin
            round_pkt.valid <= shift_pkt.valid;
        end

        if (advance) begin
            round_pkt.id <= shift_pkt.id;
            round_pkt.sign <= shift_pkt.sign;
            round_pkt.rm <= shift_pkt.rm;
            round_pkt.fflags <= fflags_next;
            round_pkt.expo <= shift_pkt.expo_norm[EXPO_WIDTH-1:0];
            round_pkt.frac <= frac_norm;
            round_pkt.expo_overflow <= shift_pkt.expo_overflow;
            round_pkt.hidden <= hidden_norm;
            round_pkt.round_lsb <= frac_norm[0];
            round_pkt.round_grs <= round_grs;
        end
    end

endmodule

// ==== norm_round/fp_round_output.sv ====
// Final rounding, overflow handling and flag generation
// Purely combinational from the third stage register
// Tininess is taken before rounding, uf needs nx and a clear hidden bit
// A carried-in nv masks the new of, nx and uf contributions
`timescale 1ns/100ps

module fp_round_output (
    input  fp_nr_pkg::round_packet_t    round_pkt,
    output fp_nr_pkg::wb_result_t       result,
    output logic                        result_done,
    input  logic                        result_ack,
    output logic                        advance
);
    import fp_nr_pkg::*;

    roundup_t rnd;
    logic frac_carry;
    logic [FRAC_WIDTH-1:0] frac_out;
    logic [EXPO_WIDTH-1:0] expo_out;
    logic overflow;
    logic new_flags_ok;

    //////////////////////////////////////////////////////////////////////
    // Rounding

    assign rnd = fp_roundup(round_pkt.sign, round_pkt.rm, round_pkt.round_grs,
                            round_pkt.round_lsb);

    assign {frac_carry, frac_out} = {1'b0, round_pkt.frac} + (FRAC_WIDTH+1)'(rnd.roundup);

    // A full fraction rolls into the exponent, also takes subnormals to normal
    assign expo_out = round_pkt.expo + EXPO_WIDTH'(frac_carry);

    // Overflow from normalization or from rounding out of the top exponent
    assign overflow = round_pkt.expo_overflow |
                      (frac_carry & (round_pkt.expo == EXPO_WIDTH'(EXPO_MAX - 1)));

    //////////////////////////////////////////////////////////////////////
    // Result and flags

    always_comb begin
        result.id = round_pkt.id;
        if (overflow) begin
            result.rd = rnd.overflow_result;
        end else begin
            result.rd.sign = round_pkt.sign;
            result.rd.expo = expo_out;
            result.rd.frac = frac_out;
        end
    end

    assign new_flags_ok = ~round_pkt.fflags.nv;

    always_comb begin
        result.fflags = round_pkt.fflags;
        result.fflags.of = round_pkt.fflags.of | (new_flags_ok & overflow);
        // Overflow is always inexact
        result.fflags.nx = round_pkt.fflags.nx | (new_flags_ok & overflow);
        result.fflags.uf = round_pkt.fflags.uf |
                           (new_flags_ok & round_pkt.fflags.nx & ~round_pkt.hidden);
    end

    assign result_done = round_pkt.valid;

    // Output slot frees up once the consumer takes the result
    assign advance = result_ack;

endmodule

// ==== design/wb_arbiter.sv ====
// Fixed-priority writeback selection, index 0 wins
// ack is combinational and only asserted for the selected unit
// The first pipeline register loads on the same edge as the ack
`timescale 1ns/100ps

module wb_arbiter #(
    parameter int NUM_WB_UNITS = fp_nr_pkg::NUM_WB_UNITS_DEFAULT
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  fp_nr_pkg::wb_req_t [NUM_WB_UNITS-1:0]   req,
    input  logic [NUM_WB_UNITS-1:0]                 done,
    output logic [NUM_WB_UNITS-1:0]                 ack,
    input  logic                                    advance_next,
    output fp_nr_pkg::norm_packet_t                 norm_pkt,
    output logic                                    advance
);
    import fp_nr_pkg::*;

    logic [NUM_WB_UNITS-1:0] grant;
    wb_req_t sel_req;

    //////////////////////////////////////////////////////////////////////
    // Selection

    // Isolate the lowest set done bit
    assign grant = done & (~done + NUM_WB_UNITS'(1));

    always_comb begin
        sel_req = '0;
        for (int i = 0; i < NUM_WB_UNITS; i++) begin
            if (grant[i]) begin
                sel_req = req[i];
            end
        end
    end

    assign advance = advance_next | ~norm_pkt.valid;
    assign ack = grant & {NUM_WB_UNITS{advance}};

    //////////////////////////////////////////////////////////////////////
    // First stage register

    always_ff @(posedge clk) begin
        if (rst) begin
            norm_pkt.valid <= 1'b0;
        end else if (advance) begin
            norm_pkt.valid <= |done;
        end

        if (advance) begin
            norm_pkt.req <= sel_req;
        end
    end

endmodule

// ==== design/fp_norm_round_top.sv ====
// Normalize-and-round back end for single-precision results
// Lower unit index has priority, a unit holds done and req until it sees ack
// Three register stages, result holds until result_ack at a rising edge
`timescale 1ns/100ps

module fp_norm_round_top #(
    parameter int NUM_WB_UNITS = fp_nr_pkg::NUM_WB_UNITS_DEFAULT
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  fp_nr_pkg::wb_req_t [NUM_WB_UNITS-1:0]   req,
    input  logic [NUM_WB_UNITS-1:0]                 done,
    output logic [NUM_WB_UNITS-1:0]                 ack,
    output fp_nr_pkg::wb_result_t                   result,
    output logic                                    result_done,
    input  logic                                    result_ack
);
    import fp_nr_pkg::*;

    norm_packet_t norm_pkt;
    shift_packet_t shift_pkt;
    round_packet_t round_pkt;
    logic advance_shift;
    logic advance_round;
    logic advance_out;

    wb_arbiter #(.NUM_WB_UNITS(NUM_WB_UNITS)) u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .done         (done),
        .ack          (ack),
        .advance_next (advance_shift),
        .norm_pkt     (norm_pkt),
        .advance      ()
    );

    fp_normalize_stage u_normalize (
        .clk          (clk),
        .rst          (rst),
        .norm_pkt     (norm_pkt),
        .advance_next (advance_round),
        .advance      (advance_shift),
        .shift_pkt    (shift_pkt)
    );

    fp_shift_extract u_shift_extract (
        .clk          (clk),
        .rst          (rst),
        .shift_pkt    (shift_pkt),
        .advance_next (advance_out),
        .advance      (advance_round),
        .round_pkt    (round_pkt)
    );

    fp_round_output u_round_output (
        .round_pkt    (round_pkt),
        .result       (result),
        .result_done  (result_done),
        .result_ack   (result_ack),
        .advance      (advance_out)
    );

endmodule

// ==== bench/fp_ref_model.svh ====
// Expected results for the normalize-and-round back end, built from the format rules
// Included inside the testbench module after the package import
// Left shifts drop whatever leaves the carry and safe positions
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

localparam int HID_POS = GRS_WIDTH + FRAC_WIDTH;

// Round-up decision from sign, mode, kept lsb and guard, round, sticky
function automatic logic ref_roundup(input logic sign, input rm_t rm, input logic lsb,
                                     input logic g, input logic r, input logic s);
    case (rm)
        RM_RTZ: return 1'b0;
        RM_RDN: return sign & (g | r | s);
        RM_RUP: return ~sign & (g | r | s);
        RM_RMM: return g;
        default: return g & (r | s | lsb);
    endcase
endfunction

function automatic wb_result_t ref_result(input wb_req_t r);
    logic [SHIFT_WIDTH-1:0] mant;
    logic [SHIFT_WIDTH-1:0] shifted;
    logic lost;
    logic sticky;
    logic up;
    logic nx_pre;
    logic ovf;
    logic to_max;
    logic [FRAC_WIDTH:0] frac_sum;
    int expo;
    int amt;
    wb_result_t res;

    mant = {r.carry, r.safe, r.hidden, r.frac, r.grs};
    lost = 1'b0;
    if (r.right_shift) begin
        amt = int'(r.right_shift_amt);
        expo = int'(r.expo) + amt;
        shifted = mant >> amt;
        for (int i = 0; i < SHIFT_WIDTH; i++) begin
            if (i < amt) lost = lost | mant[i];
        end
    end else if (int'(r.expo) > int'(r.clz)) begin
        expo = int'(r.expo) - int'(r.clz);
        shifted = mant << r.clz;
    end else begin
        // Stop at the scale of exponent 1, result is subnormal
        amt = (r.expo == '0) ? 0 : int'(r.expo) - 1;
        expo = 0;
        shifted = mant << amt;
    end

    sticky = shifted[0] | lost;
    nx_pre = r.fflags.nx | shifted[2] | shifted[1] | sticky;
    up = ref_roundup(r.sign, r.rm, shifted[GRS_WIDTH], shifted[2], shifted[1], sticky);
    frac_sum = {1'b0, shifted[HID_POS-1:GRS_WIDTH]} + (FRAC_WIDTH+1)'(up);
    ovf = (expo >= EXPO_MAX) || (frac_sum[FRAC_WIDTH] && expo == EXPO_MAX - 1);

    res.id = r.id;
    res.fflags = r.fflags;
    res.fflags.of = r.fflags.of | (ovf & ~r.fflags.nv);
    res.fflags.nx = nx_pre | (ovf & ~r.fflags.nv);
    res.fflags.uf = r.fflags.uf | (~r.fflags.nv & nx_pre & ~shifted[HID_POS]);

    res.rd.sign = r.sign;
    if (ovf) begin
        to_max = (r.rm == RM_RTZ) || (r.rm == RM_RDN && !r.sign) || (r.rm == RM_RUP && r.sign);
        res.rd.expo = to_max ? EXPO_WIDTH'(EXPO_MAX - 1) : EXPO_WIDTH'(EXPO_MAX);
        res.rd.frac = to_max ? '1 : '0;
    end else begin
        res.rd.expo = EXPO_WIDTH'(expo) + EXPO_WIDTH'(frac_sum[FRAC_WIDTH]);
        res.rd.frac = frac_sum[FRAC_WIDTH-1:0];
    end
    return res;
endfunction

`endif

// ==== bench/tb_fp_norm_round.sv ====
// Testbench for the normalize-and-round back end with four writeback units
// Each unit has its own request list
// The monitor predicts results at every ack
// Outputs are sampled at rising edges, before the edge's register updates land
`timescale 1ns/100ps

module tb_fp_norm_round;
    import fp_nr_pkg::*;
    `include "fp_ref_model.svh"

    localparam int UNITS = 4;
    localparam int SRC_DEPTH = 256;
    localparam int TIMEOUT = 3000;

    logic clk;
    logic rst;
    wb_req_t [UNITS-1:0] req;
    logic [UNITS-1:0] done;
    logic [UNITS-1:0] ack;
    wb_result_t result;
    logic result_done;
    logic result_ack;

    integer seed;
    wb_req_t src_mem [UNITS][SRC_DEPTH];
    int src_wr [UNITS];
    int src_rd [UNITS];
    wb_result_t exp_q [$];
    int ack_cycle_q [$];
    int cycle;
    int stretch;
    logic stall_mode;
    logic latency_mode;
    logic held_valid;
    wb_result_t held_result;

    fp_norm_round_top #(.NUM_WB_UNITS(UNITS)) u_dut (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .done        (done),
        .ack         (ack),
        .result      (result),
        .result_done (result_done),
        .result_ack  (result_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic add_request(input int unit, input wb_req_t r);
        src_mem[unit][src_wr[unit] % SRC_DEPTH] = r;
        src_wr[unit] = src_wr[unit] + 1;
    endtask

    // Kind 1 gives an exact tie, 2 a clamped left shift and 3 a right shift
    task automatic random_req(input id_t id, input int kind, output wb_req_t r);
        logic [31:0] rnd;
        logic [31:0] rnd2;
        rnd = $random(seed);
        rnd2 = $random(seed);
        r = '0;
        r.id = id;
        r.sign = rnd[31];
        r.rm = rnd[30:28] % 3'd5;
        r.expo = EXPO_WIDTH'(rnd[10:3] % 8'd200) + 8'd1;
        r.hidden = 1'b1;
        r.frac = rnd2[FRAC_WIDTH-1:0];
        r.grs = rnd[2:0];
        case (kind)
            1: r.grs = 3'b100;
            2: begin
                r.hidden = 1'b0;
                r.expo = 8'd1 + EXPO_WIDTH'(rnd[13:11]);
                r.clz = shift_amt_t'(rnd[17:14]) + r.expo[4:0];
                r.frac = rnd2[FRAC_WIDTH-1:0] >> r.clz;
            end
            3: begin
                r.carry = rnd[18];
                r.safe = rnd[19];
                r.right_shift = 1'b1;
                r.right_shift_amt = rnd[24:20];
            end
            default: ;
        endcase
    endtask

    task automatic wait_for_ack();
        int n;
        n = 0;
        while (ack === '0) begin
            @(negedge clk);
            n = n + 1;
            if (n > TIMEOUT) stop_run("Timeout waiting for an ack");
        end
    endtask

    task automatic wait_drain();
        int n;
        logic busy;
        n = 0;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = (exp_q.size() != 0) || result_done || (done != '0);
            for (int i = 0; i < UNITS; i++) begin
                if (src_rd[i] < src_wr[i]) busy = 1'b1;
            end
            n = n + 1;
            if (n > TIMEOUT) stop_run("Timeout waiting for the pipeline to drain");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Unit and consumer drivers

    always @(posedge clk) begin
        for (int i = 0; i < UNITS; i++) begin
            if (done[i] && ack[i]) src_rd[i] = src_rd[i] + 1;
            done[i] <= (src_rd[i] < src_wr[i]);
            req[i] <= src_mem[i][src_rd[i] % SRC_DEPTH];
        end
    end

    // Random stretches of stall and flow
    always @(posedge clk) begin
        if (!stall_mode) begin
            result_ack <= 1'b1;
        end else if (stretch == 0) begin
            result_ack <= ~result_ack;
            stretch = 1 + ($random(seed) & 7);
        end else begin
            stretch = stretch - 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Monitor and scoreboard

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!rst) begin
            if (held_valid) begin
                assert (result_done === 1'b1) else stop_run($sformatf(
                    "[ERROR] %0t result_done (stalled) got %b expected %b", $time,
                    result_done, 1'b1));
                assert (result === held_result) else stop_run($sformatf(
                    "[ERROR] %0t result (stalled) got %h expected %h", $time, result, held_result));
            end
            if (result_done && result_ack) begin
                assert (exp_q.size() > 0) else stop_run("A result arrived with nothing in flight");
                assert (result.id === exp_q[0].id) else stop_run($sformatf(
                    "[ERROR] %0t result.id got %h expected %h", $time, result.id, exp_q[0].id));
                assert (result.rd === exp_q[0].rd) else stop_run($sformatf(
                    "[ERROR] %0t result.rd got %h expected %h", $time, result.rd, exp_q[0].rd));
                assert (result.fflags === exp_q[0].fflags) else stop_run($sformatf(
                    "[ERROR] %0t result.fflags got %b expected %b", $time, result.fflags,
                    exp_q[0].fflags));
                if (latency_mode) begin
                    assert (cycle - ack_cycle_q[0] == 3) else stop_run($sformatf(
                        "[ERROR] %0t latency got %0d expected 3", $time, cycle - ack_cycle_q[0]));
                end
                void'(exp_q.pop_front());
                void'(ack_cycle_q.pop_front());
            end
            held_valid = result_done && !result_ack;
            held_result = result;
            assert ($onehot0(ack)) else stop_run("More than one ack raised in a cycle");
            for (int i = 0; i < UNITS; i++) begin
                if (ack[i]) begin
                    assert (done[i]) else stop_run("ack raised for a unit without done");
                    exp_q.push_back(ref_result(req[i]));
                    ack_cycle_q.push_back(cycle);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        wb_req_t r;
        seed = 34041;
        rst = 1'b1;
        req = '0;
        done = '0;
        result_ack = 1'b0;
        stall_mode = 1'b0;
        latency_mode = 1'b1;
        held_valid = 1'b0;
        held_result = '0;
        stretch = 0;
        cycle = 0;
        for (int i = 0; i < UNITS; i++) begin
            src_wr[i] = 0;
            src_rd[i] = 0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (result_done === 1'b0) else stop_run($sformatf(
            "[ERROR] %0t result_done got %b expected %b", $time, result_done, 1'b0));
        assert (ack === '0) else stop_run($sformatf(
            "[ERROR] %0t ack got %b expected %b", $time, ack, 4'b0000));

        // Units 1 and 3 at once with unit 1 expected to win
        random_req(4'd1, 0, r);
        add_request(1, r);
        random_req(4'd3, 0, r);
        add_request(3, r);
        wait_for_ack();
        assert (ack === 4'b0010) else stop_run($sformatf(
            "[ERROR] %0t ack got %b expected %b", $time, ack, 4'b0010));
        wait_drain();

        // Random rounding in all modes with every fifth an exact tie
        for (int n = 0; n < 60; n++) begin
            random_req(id_t'(n), (n % 5 == 0) ? 1 : 0, r);
            add_request(n % UNITS, r);
        end
        wait_drain();

        // Left shifts clamped at the subnormal boundary
        for (int n = 0; n < 16; n++) begin
            random_req(id_t'(n), 2, r);
            add_request(n % UNITS, r);
        end
        wait_drain();

        // Overflow by rounding carry, by right shift, and with nv carried in
        for (int m = 0; m < 5; m++) begin
            for (int s = 0; s < 2; s++) begin
                r = '0;
                r.id = id_t'(m * 2 + s);
                r.sign = s[0];
                r.rm = rm_t'(m);
                r.expo = 8'd254;
                r.hidden = 1'b1;
                r.frac = '1;
                r.grs = 3'b111;
                add_request(0, r);
                r.fflags.nv = 1'b1;
                add_request(2, r);
                r = '0;
                r.id = id_t'(m * 2 + s);
                r.sign = s[0];
                r.rm = rm_t'(m);
                r.expo = 8'd253;
                r.carry = 1'b1;
                r.right_shift = 1'b1;
                r.right_shift_amt = 5'd2;
                add_request(1, r);
            end
        end
        wait_drain();

        // All units busy while the consumer stalls at random
        latency_mode = 1'b0;
        stall_mode = 1'b1;
        for (int n = 0; n < 48; n++) begin
            random_req(id_t'(n), n % 4, r);
            add_request(n % UNITS, r);
        end
        wait_drain();
        stall_mode = 1'b0;
        latency_mode = 1'b1;
        repeat (4) @(negedge clk);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+bench
common/fp_nr_pkg.sv
norm_round/fp_normalize_stage.sv
norm_round/fp_shift_extract.sv
norm_round/fp_round_output.sv
design/wb_arbiter.sv
design/fp_norm_round_top.sv
bench/tb_fp_norm_round.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the back-end testbench with Verilator
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
    --top-module tb_fp_norm_round --Mdir obj_dir -o tb_fp_norm_round
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed"
    exit "$status"
fi

./obj_dir/tb_fp_norm_round
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed"
    exit "$status"
fi

exit 0
